//--- src/core_pkg.sv
package core_pkg;

    // ========================================================================
    // Widths
    // ========================================================================

    parameter int XLEN        = 32;
    // Instructions per fetch bundle
    parameter int ISSUE_WIDTH = 3;

    // Architectural register index
    typedef logic [4:0] reg_addr_t;

    // RV32I major opcodes known to the decoder
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // ========================================================================
    // Instruction formats, one word read six ways
    // ========================================================================

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Store immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // Branch offset bits scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        logic [XLEN-1:0] raw;
        r_type_t         r_type;
        i_type_t         i_type;
        s_type_t         s_type;
        b_type_t         b_type;
        u_type_t         u_type;
        j_type_t         j_type;
    } instr_t;

    // Decoded class, one per opcode plus illegal
    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_SYSTEM,
        CLS_ILLEGAL
    } inst_class_e;

    // ========================================================================
    // Bundles between stages
    // ========================================================================

    // Lane k sits at pc + 4k
    typedef struct packed {
        logic [XLEN-1:0]              pc;
        instr_t [ISSUE_WIDTH-1:0]     words;
    } fetch_bundle_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_class_e     inst_class;
        reg_addr_t       rd;
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        logic            rd_write;
        logic [XLEN-1:0] imm;
    } decoded_t;

    // Indexed by lane
    typedef decoded_t [ISSUE_WIDTH-1:0] decoded_bundle_t;

    typedef struct packed {
        logic [31:0] cycles;
        logic [31:0] fetched;
        logic [31:0] issued;
        logic [31:0] buffer_stalls;
    } perf_t;

endpackage

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                                               clk,
    input  logic                                               reset,
    // Buffer back-pressure
    input  logic                                               full_i,
    // Three-port instruction memory, same-cycle answer
    input  core_pkg::instr_t [core_pkg::ISSUE_WIDTH-1:0]       inst_data_i,
    output logic [core_pkg::ISSUE_WIDTH-1:0][core_pkg::XLEN-1:0] inst_addr_o,
    // Bundle push towards the buffer
    output logic                                               push_o,
    output core_pkg::fetch_bundle_t                            push_bundle_o,
    output logic                                               stall_o
);

    import core_pkg::*;

    // Bytes covered by one bundle
    localparam logic [XLEN-1:0] BUNDLE_BYTES = XLEN'(4 * ISSUE_WIDTH);

    // PC of lane 0
    logic [XLEN-1:0] pc_q;

    // ========================================================================
    // Fetch addresses
    // ========================================================================

    // Consecutive words pc, pc+4, pc+8
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            inst_addr_o[k] = pc_q + XLEN'(4 * k);
        end
    end

    // ========================================================================
    // Push and stall
    // ========================================================================

    // Push whenever the buffer has room
    assign push_o  = !full_i;
    // Full buffer means a lost fetch slot
    assign stall_o = full_i;

    // Memory words go straight into the bundle
    assign push_bundle_o.pc    = pc_q;
    assign push_bundle_o.words = inst_data_i;

    // PC advances by a whole bundle on push, holds otherwise
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= RESET_PC;
        end else if (push_o) begin
            pc_q <= pc_q + BUNDLE_BYTES;
        end
    end

endmodule

//--- src/instruction_buffer.sv
`timescale 1ns/1ps

module instruction_buffer #(
    parameter int unsigned BUFFER_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    // Write side from fetch
    input  logic                    push_i,
    input  core_pkg::fetch_bundle_t push_bundle_i,
    // Read side towards decode
    input  logic                    pop_i,
    output core_pkg::fetch_bundle_t head_o,
    output logic                    not_empty_o,
    output logic                    full_o
);

    import core_pkg::*;

    // At least one pointer bit, even for depth 1
    localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(BUFFER_DEPTH - 1);
    localparam logic [PTR_W:0]   DEPTH_CNT = (PTR_W + 1)'(BUFFER_DEPTH);

    // Bundle storage
    fetch_bundle_t    mem_q [BUFFER_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    // Occupancy, 0 to BUFFER_DEPTH
    logic [PTR_W:0]   count_q;

    logic             wr_en;
    logic             rd_en;

    // Wrap without needing a power-of-two depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
    endfunction

    // ========================================================================
    // Status and handshake
    // ========================================================================

    assign not_empty_o = (count_q != '0);
    assign full_o      = (count_q == DEPTH_CNT);

    // Push into a full buffer only if a slot frees in the same cycle
    assign wr_en = push_i && (!full_o || pop_i);
    assign rd_en = pop_i && not_empty_o;

    // Head read straight from storage
    assign head_o = mem_q[rd_ptr_q];

    // ========================================================================
    // Pointers and occupancy
    // ========================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (rd_en) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Simultaneous push and pop leave the count alone
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= push_bundle_i;
        end
    end

endmodule

//--- src/decode_lane.sv
`timescale 1ns/1ps

module decode_lane (
    input  core_pkg::instr_t           word_i,
    input  logic [core_pkg::XLEN-1:0]  pc_i,
    output core_pkg::decoded_t         decoded_o
);

    import core_pkg::*;

    decoded_t dec;
    // Class allowed to write rd at all
    logic     writes_rd;

    // ========================================================================
    // Opcode decode and immediate build
    // ========================================================================

    always_comb begin
        dec    = '0;
        dec.pc = pc_i;
        // Opcode lives at the same bits in every format
        case (opcode_e'(word_i.raw[6:0]))
            OPC_OP: begin
                dec.inst_class = CLS_OP;
                dec.rd         = word_i.r_type.rd;
                dec.rs1        = word_i.r_type.rs1;
                dec.rs2        = word_i.r_type.rs2;
            end
            OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_SYSTEM: begin
                case (opcode_e'(word_i.raw[6:0]))
                    OPC_OP_IMM: dec.inst_class = CLS_OP_IMM;
                    OPC_LOAD:   dec.inst_class = CLS_LOAD;
                    OPC_JALR:   dec.inst_class = CLS_JALR;
                    default:    dec.inst_class = CLS_SYSTEM;
                endcase
                dec.rd  = word_i.i_type.rd;
                dec.rs1 = word_i.i_type.rs1;
                dec.imm = {{20{word_i.i_type.imm[11]}}, word_i.i_type.imm};
            end
            OPC_STORE: begin
                dec.inst_class = CLS_STORE;
                dec.rs1        = word_i.s_type.rs1;
                dec.rs2        = word_i.s_type.rs2;
                dec.imm        = {{20{word_i.s_type.imm_hi[6]}},
                                  word_i.s_type.imm_hi, word_i.s_type.imm_lo};
            end
            OPC_BRANCH: begin
                dec.inst_class = CLS_BRANCH;
                dec.rs1        = word_i.b_type.rs1;
                dec.rs2        = word_i.b_type.rs2;
                // Even offset, bit 0 always zero
                dec.imm        = {{19{word_i.b_type.imm12}}, word_i.b_type.imm12,
                                  word_i.b_type.imm11, word_i.b_type.imm10_5,
                                  word_i.b_type.imm4_1, 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                dec.inst_class = (word_i.raw[6:0] == OPC_LUI) ? CLS_LUI : CLS_AUIPC;
                dec.rd         = word_i.u_type.rd;
                // Upper 20 bits, low 12 zero
                dec.imm        = {word_i.u_type.imm, 12'b0};
            end
            OPC_JAL: begin
                dec.inst_class = CLS_JAL;
                dec.rd         = word_i.j_type.rd;
                dec.imm        = {{11{word_i.j_type.imm20}}, word_i.j_type.imm20,
                                  word_i.j_type.imm19_12, word_i.j_type.imm11,
                                  word_i.j_type.imm10_1, 1'b0};
            end
            default: begin
                // Unknown opcode, registers and immediate stay zero
                dec.inst_class = CLS_ILLEGAL;
            end
        endcase
    end

    // ========================================================================
    // Register write flag
    // ========================================================================

    // Branches, stores and illegal words never write rd
    assign writes_rd = !(dec.inst_class inside {CLS_BRANCH, CLS_STORE, CLS_ILLEGAL});

    // x0 writes are dropped here
    always_comb begin
        decoded_o          = dec;
        decoded_o.rd_write = writes_rd && (dec.rd != '0);
    end

endmodule

//--- src/issue_register.sv
`timescale 1ns/1ps

module issue_register (
    input  logic                      clk,
    input  logic                      reset,
    // Decoded lanes of the buffer head
    input  core_pkg::decoded_bundle_t lanes_i,
    input  logic                      not_empty_i,
    // Fetch events for the counters
    input  logic                      push_i,
    input  logic                      stall_i,
    // Output handshake
    input  logic                      out_ready_i,
    output logic                      pop_o,
    output logic                      out_valid_o,
    output core_pkg::decoded_bundle_t out_bundle_o,
    output core_pkg::perf_t           perf_o
);

    import core_pkg::*;

    // Instructions per pushed or issued bundle
    localparam logic [31:0] BUNDLE_INSTRS = 32'(ISSUE_WIDTH);

    // Stage empty, or its content leaves this cycle
    logic can_load;
    // Bundle accepted downstream on this edge
    logic transfer;

    // ========================================================================
    // One-entry output stage
    // ========================================================================

    assign can_load = !out_valid_o || out_ready_i;
    assign pop_o    = not_empty_i && can_load;
    assign transfer = out_valid_o && out_ready_i;

    // Valid follows the buffer whenever the stage may load
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            out_valid_o <= 1'b0;
        end else if (can_load) begin
            out_valid_o <= not_empty_i;
        end
    end

    // Payload only moves on pop, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (pop_o) begin
            out_bundle_o <= lanes_i;
        end
    end

    // ========================================================================
    // Performance counters
    // ========================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            perf_o <= '0;
        end else begin
            perf_o.cycles <= perf_o.cycles + 1'b1;
            // Whole bundles, three at a time
            if (push_i) begin
                perf_o.fetched <= perf_o.fetched + BUNDLE_INSTRS;
            end
            if (transfer) begin
                perf_o.issued <= perf_o.issued + BUNDLE_INSTRS;
            end
            // One per cycle with fetch blocked by a full buffer
            if (stall_i) begin
                perf_o.buffer_stalls <= perf_o.buffer_stalls + 1'b1;
            end
        end
    end

endmodule

//--- src/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter int unsigned               BUFFER_DEPTH = 4,
    parameter logic [core_pkg::XLEN-1:0] RESET_PC     = '0
) (
    input  logic                                                 clk,
    input  logic                                                 reset,
    // Instruction memory
    output logic [core_pkg::ISSUE_WIDTH-1:0][core_pkg::XLEN-1:0] inst_addr_o,
    input  core_pkg::instr_t [core_pkg::ISSUE_WIDTH-1:0]         inst_data_i,
    // Issue handshake
    output logic                                                 out_valid_o,
    input  logic                                                 out_ready_i,
    output core_pkg::decoded_bundle_t                            out_bundle_o,
    output core_pkg::perf_t                                      perf_o
);

    import core_pkg::*;

    // Fetch to buffer
    logic            push;
    fetch_bundle_t   push_bundle;
    logic            stall;
    logic            full;
    // Buffer to decode and issue
    fetch_bundle_t   head;
    logic            not_empty;
    logic            pop;
    decoded_bundle_t lanes;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) i_fetch_unit (
        .clk          (clk),
        .reset        (reset),
        .full_i       (full),
        .inst_data_i  (inst_data_i),
        .inst_addr_o  (inst_addr_o),
        .push_o       (push),
        .push_bundle_o(push_bundle),
        .stall_o      (stall)
    );

    instruction_buffer #(
        .BUFFER_DEPTH(BUFFER_DEPTH)
    ) i_instruction_buffer (
        .clk          (clk),
        .reset        (reset),
        .push_i       (push),
        .push_bundle_i(push_bundle),
        .pop_i        (pop),
        .head_o       (head),
        .not_empty_o  (not_empty),
        .full_o       (full)
    );

    // One decoder per word of the head bundle
    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_lane
        decode_lane i_decode_lane (
            .word_i   (head.words[k]),
            .pc_i     (head.pc + XLEN'(4 * k)),
            .decoded_o(lanes[k])
        );
    end

    issue_register i_issue_register (
        .clk         (clk),
        .reset       (reset),
        .lanes_i     (lanes),
        .not_empty_i (not_empty),
        .push_i      (push),
        .stall_i     (stall),
        .out_ready_i (out_ready_i),
        .pop_o       (pop),
        .out_valid_o (out_valid_o),
        .out_bundle_o(out_bundle_o),
        .perf_o      (perf_o)
    );

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk_o
);

    // Free-running, low for the first half period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

//--- verification/frontend_props.sv
`timescale 1ns/1ps

module frontend_props (
    input logic                      clk,
    input logic                      reset,
    input logic                      valid_i,
    input logic                      ready_i,
    input logic                      push_i,
    input logic                      pop_i,
    input core_pkg::decoded_bundle_t bundle_i
);

    // Count of failed assertions
    int fail_count = 0;
    // Bundles held in the buffer, tracked from pushes and pops
    int occupancy;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push_i) - int'(pop_i);
        end
    end

    // ========================================================================
    // Output handshake
    // ========================================================================

    // Stalled output keeps valid and payload
    stalled_output_stable: assert property (@(posedge clk) disable iff (!reset)
        (valid_i && !ready_i) |=> (valid_i && $stable(bundle_i)))
        else begin
            fail_count++;
            $error("output bundle changed while stalled");
        end

    // No valid on the first two edges out of reset
    valid_low_after_reset: assert property (@(posedge clk)
        $rose(reset) |-> !valid_i ##1 !valid_i)
        else begin
            fail_count++;
            $error("out_valid_o high right after reset");
        end

    // ========================================================================
    // Buffer side
    // ========================================================================

    // Pop only from a buffer that holds a bundle
    no_pop_when_empty: assert property (@(posedge clk) disable iff (!reset)
        pop_i |-> (occupancy != 0))
        else begin
            fail_count++;
            $error("pop while the instruction buffer is empty");
        end

endmodule

bind issue_register frontend_props i_frontend_props (
    .clk     (clk),
    .reset   (reset),
    .valid_i (out_valid_o),
    .ready_i (out_ready_i),
    .push_i  (push_i),
    .pop_i   (pop_o),
    .bundle_i(out_bundle_o)
);

//--- verification/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

    import core_pkg::*;

    localparam int unsigned     BUFFER_DEPTH   = 4;
    localparam logic [XLEN-1:0] RESET_PC       = '0;
    localparam real             CLK_PERIOD     = 100.0;
    localparam int              RUN_TRANSFERS  = 120;
    // Output hold starts after this many transfers
    localparam int              HOLD_AFTER     = 40;
    localparam int              HOLD_CYCLES    = 30;
    localparam int              TIMEOUT_CYCLES = 600;

    // Opcodes the decoder knows
    localparam logic [6:0] LEGAL_OPC [10] = '{
        7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
        7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b1110011
    };

    logic                             clk;
    logic                             reset;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0] inst_addr;
    instr_t [ISSUE_WIDTH-1:0]         inst_data;
    logic                             out_valid;
    logic                             out_ready;
    decoded_bundle_t                  out_bundle;
    perf_t                            perf;

    logic [31:0]     mem_table [64];
    integer          seed;
    int              errors;
    int              transfers;
    int              cycles_seen;
    int              prop_errors;
    logic [XLEN-1:0] expected_pc;
    logic            stalled_prev;
    decoded_bundle_t stalled_bundle;
    logic [31:0]     in_flight;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_clock (.clk_o(clk));

    frontend_top #(
        .BUFFER_DEPTH(BUFFER_DEPTH),
        .RESET_PC    (RESET_PC)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .inst_addr_o (inst_addr),
        .inst_data_i (inst_data),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .out_bundle_o(out_bundle),
        .perf_o      (perf)
    );

    // ========================================================================
    // Instruction memory model
    // ========================================================================

    // Same-cycle answer with the word index from address bits 7:2
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            inst_data[k].raw = mem_table[inst_addr[k][7:2]];
        end
    end

    // ========================================================================
    // Reference decode from the RV32I encodings
    // ========================================================================

    function automatic decoded_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
        decoded_t d;
        d            = '0;
        d.pc         = pc;
        d.inst_class = CLS_ILLEGAL;
        case (w[6:0])
            7'b0110111: d.inst_class = CLS_LUI;
            7'b0010111: d.inst_class = CLS_AUIPC;
            7'b1101111: d.inst_class = CLS_JAL;
            7'b1100111: d.inst_class = CLS_JALR;
            7'b1100011: d.inst_class = CLS_BRANCH;
            7'b0000011: d.inst_class = CLS_LOAD;
            7'b0100011: d.inst_class = CLS_STORE;
            7'b0010011: d.inst_class = CLS_OP_IMM;
            7'b0110011: d.inst_class = CLS_OP;
            7'b1110011: d.inst_class = CLS_SYSTEM;
            default:    d.inst_class = CLS_ILLEGAL;
        endcase
        // Fields by format
        case (d.inst_class)
            CLS_OP: begin
                d.rd  = w[11:7];
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
            end
            CLS_OP_IMM, CLS_LOAD, CLS_JALR, CLS_SYSTEM: begin
                d.rd  = w[11:7];
                d.rs1 = w[19:15];
                d.imm = {{20{w[31]}}, w[31:20]};
            end
            CLS_STORE: begin
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            CLS_BRANCH: begin
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            CLS_LUI, CLS_AUIPC: begin
                d.rd  = w[11:7];
                d.imm = {w[31:12], 12'b0};
            end
            CLS_JAL: begin
                d.rd  = w[11:7];
                d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                // Illegal keeps everything zero
                d.rd = '0;
            end
        endcase
        d.rd_write = !(d.inst_class inside {CLS_BRANCH, CLS_STORE, CLS_ILLEGAL})
                     && (d.rd != 5'd0);
        return d;
    endfunction

    task automatic expect_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // ========================================================================
    // Compare process on the rising edge
    // ========================================================================

    always @(posedge clk) begin
        if (reset) begin
            cycles_seen++;
            // Payload held since the last stalled edge
            if (stalled_prev) begin
                expect_value("out_valid_o", 128'(out_valid), 128'(1'b1));
                for (int k = 0; k < ISSUE_WIDTH; k++) begin
                    expect_value($sformatf("out_bundle_o[%0d]", k), 128'(out_bundle[k]),
                                 128'(stalled_bundle[k]));
                end
            end
            if (out_valid && out_ready) begin
                for (int k = 0; k < ISSUE_WIDTH; k++) begin
                    expect_value($sformatf("out_bundle_o[%0d]", k), 128'(out_bundle[k]),
                                 128'(ref_decode(mem_table[expected_pc[7:2] + 6'(k)],
                                                 expected_pc + 32'(4 * k))));
                end
                expected_pc = expected_pc + 32'(4 * ISSUE_WIDTH);
                transfers++;
            end
            stalled_prev   = out_valid && !out_ready;
            stalled_bundle = out_bundle;
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        logic [31:0] word;
        int unsigned sel;
        logic        hold_done;
        errors       = 0;
        transfers    = 0;
        cycles_seen  = 0;
        expected_pc  = RESET_PC;
        stalled_prev = 1'b0;
        hold_done    = 1'b0;
        reset        = 1'b0;
        out_ready    = 1'b0;
        seed         = 32'hddf3db1e;
        // Every eighth word keeps an illegal opcode
        for (int i = 0; i < 64; i++) begin
            word = $random(seed);
            sel  = $unsigned($random(seed)) % 10;
            if (i % 8 == 7) begin
                word[1:0] = 2'b00;
            end else begin
                word[6:0] = LEGAL_OPC[sel];
            end
            // Some x0 destinations
            if (i % 8 == 3) begin
                word[11:7] = 5'd0;
            end
            mem_table[i] = word;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        #1;
        expect_value("out_valid_o", 128'(out_valid), 128'(1'b0));
        expect_value("perf_o", 128'(perf), 128'(0));
        expect_value("inst_addr_o[0]", 128'(inst_addr[0]), 128'(RESET_PC));

        @(negedge clk);
        while (transfers < RUN_TRANSFERS) begin
            // One long back-pressure phase to fill the buffer
            if (!hold_done && transfers >= HOLD_AFTER) begin
                out_ready = 1'b0;
                repeat (HOLD_CYCLES) @(negedge clk);
                hold_done = 1'b1;
            end
            out_ready = ($unsigned($random(seed)) % 100) < 70;
            @(negedge clk);
        end
        out_ready = 1'b0;

        // End-of-run counters
        expect_value("perf_o.issued", 128'(perf.issued), 128'(32'(3 * transfers)));
        expect_value("perf_o.cycles", 128'(perf.cycles), 128'(32'(cycles_seen)));
        in_flight = perf.fetched - perf.issued;
        assert (in_flight % 32'd3 == 32'd0 && in_flight <= 32'(3 * (BUFFER_DEPTH + 1)))
        else begin
            errors++;
            $display("fetched and issued counts disagree by %0d instructions", in_flight);
        end
        assert (perf.buffer_stalls != 32'd0) else begin
            errors++;
            $display("no buffer stall counted after the output hold");
        end

        prop_errors = i_dut.i_issue_register.i_frontend_props.fail_count;
        $display("errors: %0d testbench checks, %0d bound assertions", errors, prop_errors);
        if (errors == 0 && prop_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- verilog.f
src/core_pkg.sv
src/fetch_unit.sv
src/instruction_buffer.sv
src/decode_lane.sv
src/issue_register.sv
src/frontend_top.sv
verification/tb_clock.sv
verification/frontend_props.sv
verification/frontend_tb.sv

//--- Makefile
# Verilator build and run of the front end testbench

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
